// ==== common/noc_bridge_pkg.sv ====
// Shared types for the NoC-over-AXIS link.
// Flit channels, the one-bit channel header and the AXIS beat layout
// used by the bridges, the top level and the testbench.
// Import with noc_bridge_pkg::* in the module header.

`default_nettype none

package noc_bridge_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Flit payload width
  localparam int unsigned FlitDataWidth = 32;
  // AXIS strobe covers the 33-bit beat, rounded up to bytes
  localparam int unsigned AxisStrbWidth = 5;

  typedef logic [FlitDataWidth-1:0] flit_data_t;
  typedef logic [AxisStrbWidth-1:0] axis_strb_t;

  // Arbiter input index, 0 is request and 1 is response
  typedef logic [0:0] chan_idx_t;

  ////////////////////////////////////////
  // Channel and beat types
  ////////////////////////////////////////

  // Header bit, same encoding as chan_idx_t
  typedef enum logic {
    request  = 1'b0,
    response = 1'b1
  } channel_hdr_e;

  // Forward half of a flit channel, ready travels separately
  typedef struct packed {
    logic       valid;
    flit_data_t data;
  } flit_t;

  // Content of one AXIS beat, header on top
  typedef struct packed {
    channel_hdr_e hdr;
    flit_data_t   data;
  } axis_data_t;

  // Forward AXIS channel
  typedef struct packed {
    logic       tvalid;
    axis_data_t tdata;
    axis_strb_t tstrb;
    logic       tlast;
  } axis_req_t;

  // Backward AXIS channel
  typedef struct packed {
    logic tready;
  } axis_rsp_t;

endpackage

`default_nettype wire

// ==== noc_axis_bridge/flit_rr_arbiter.sv ====
// Two-input round-robin arbiter for flit channels.
// Picks one valid input per cycle, holds the winner until the output
// handshake completes and then hands priority to the other input.

`timescale 1ns/1ps
`default_nettype none

module flit_rr_arbiter
  import noc_bridge_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic [1:0]       valid_i,
  input  wire flit_data_t [1:0] data_i,
  output logic [1:0]            gnt_o,
  output logic                  valid_o,
  input  wire logic             ready_i,
  output flit_data_t            data_o,
  output chan_idx_t             idx_o
);

  // Favored input for the next fresh arbitration
  chan_idx_t prio_q;
  // Winner held while the output is stalled
  logic      lock_q;
  chan_idx_t lock_idx_q;
  chan_idx_t sel;
  logic      xfer;

  ////////////////////////////////////////
  // Selection
  ////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      // Stalled beat keeps its source
      sel = lock_idx_q;
    end else if (valid_i[prio_q]) begin
      sel = prio_q;
    end else begin
      // Fall back to the other input
      sel = ~prio_q;
    end
  end

  assign valid_o = valid_i[sel];
  assign data_o  = data_i[sel];
  assign idx_o   = sel;
  assign xfer    = valid_o & ready_i;

  // Grant only the selected input, and only on an actual transfer
  assign gnt_o[0] = xfer & (sel == 1'b0);
  assign gnt_o[1] = xfer & (sel == 1'b1);

  ////////////////////////////////////////
  // Priority and lock state
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Request channel wins first after reset
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else begin
      if (xfer) begin
        prio_q <= ~sel;
        lock_q <= 1'b0;
      end else if (valid_o) begin
        // Output waiting on ready, freeze the choice
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

// ==== noc_axis_bridge/noc_axis_bridge.sv ====
// One end of the NoC-over-AXIS link.
// Transmit merges request and response flits onto one AXIS lane with a
// channel header, receive decodes the header and steers the beat back
// onto the matching flit output.

`timescale 1ns/1ps
`default_nettype none

module noc_axis_bridge
  import noc_bridge_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  // Flits entering the bridge
  input  wire flit_t     req_i,
  input  wire flit_t     rsp_i,
  output logic           req_ready_o,
  output logic           rsp_ready_o,
  // Flits leaving the bridge
  output flit_t          req_o,
  output flit_t          rsp_o,
  input  wire logic      req_ready_i,
  input  wire logic      rsp_ready_i,
  // Outgoing AXIS lane
  output axis_req_t      axis_out_req_o,
  input  wire axis_rsp_t axis_out_rsp_i,
  // Incoming AXIS lane
  input  wire axis_req_t axis_in_req_i,
  output axis_rsp_t      axis_in_rsp_o
);

  logic [1:0] arb_gnt;
  logic       arb_valid;
  logic       arb_ready;
  flit_data_t arb_data;
  chan_idx_t  arb_idx;
  axis_data_t tx_payload;
  axis_data_t rx_payload;

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  // Index 0 is the request channel
  flit_rr_arbiter arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  ({rsp_i.valid, req_i.valid}),
    .data_i   ({rsp_i.data, req_i.data}),
    .gnt_o    (arb_gnt),
    .valid_o  (arb_valid),
    .ready_i  (arb_ready),
    .data_o   (arb_data),
    .idx_o    (arb_idx)
  );

  assign req_ready_o = arb_gnt[0];
  assign rsp_ready_o = arb_gnt[1];

  // Winner index doubles as the header
  assign tx_payload.hdr  = channel_hdr_e'(arb_idx);
  assign tx_payload.data = arb_data;

  stream_fifo #(
    .Depth (FifoDepth)
  ) tx_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (arb_valid),
    .ready_o  (arb_ready),
    .data_i   (tx_payload),
    .valid_o  (axis_out_req_o.tvalid),
    .ready_i  (axis_out_rsp_i.tready),
    .data_o   (axis_out_req_o.tdata)
  );

  // Every beat is complete, no packet framing
  assign axis_out_req_o.tstrb = '1;
  assign axis_out_req_o.tlast = 1'b0;

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  assign rx_payload = axis_in_req_i.tdata;

  // Only the addressed channel sees valid
  assign req_o.valid = axis_in_req_i.tvalid & (rx_payload.hdr == request);
  assign rsp_o.valid = axis_in_req_i.tvalid & (rx_payload.hdr == response);
  assign req_o.data  = rx_payload.data;
  assign rsp_o.data  = rx_payload.data;

  // Back-pressure from the addressed channel
  assign axis_in_rsp_o.tready = (rx_payload.hdr == request) ? req_ready_i : rsp_ready_i;

endmodule

`default_nettype wire

// ==== noc_axis_bridge/stream_fifo.sv ====
// Valid/ready FIFO for tagged AXIS payloads.
// Circular buffer with an occupancy count, head entry on data_o.
// Depth is set from above, 1 to 8 entries.

`timescale 1ns/1ps
`default_nettype none

module stream_fifo
  import noc_bridge_pkg::*;
#(
  parameter int unsigned Depth = 2
) (
  input  wire logic       clk_i,
  input  wire logic       arst_n_i,
  input  wire logic       valid_i,
  output logic            ready_o,
  input  wire axis_data_t data_i,
  output logic            valid_o,
  input  wire logic       ready_i,
  output axis_data_t      data_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  axis_data_t          mem [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full;
  logic                push;
  logic                pop;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  assign full    = (count_q == CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  // A full FIFO still takes a beat while the head leaves
  assign ready_o = !full | ready_i;
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  // Head entry
  assign data_o = mem[rd_ptr_q];

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at the last entry
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count only moves when exactly one side transfers
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== noc_axis_link.f ====
common/noc_bridge_pkg.sv
noc_axis_bridge/flit_rr_arbiter.sv
noc_axis_bridge/stream_fifo.sv
noc_axis_bridge/noc_axis_bridge.sv
verilog/noc_axis_link.sv
testbench/noc_axis_link_tb.sv

// ==== testbench/noc_axis_link_tb.sv ====
// Self-checking testbench for the NoC-over-AXIS link.
// Flits come from the testdata file and from an xorshift generator.
// Every output flit is checked against per-channel expected queues.

`timescale 1ns/1ps
`default_nettype none

module noc_axis_link_tb
  import noc_bridge_pkg::*;
;

  localparam int unsigned FifoDepth  = 2;
  localparam int unsigned QDepth     = 64;
  localparam int unsigned MaxRecords = 64;

  // Channel slots: 0 a_req, 1 a_rsp, 2 b_req, 3 b_rsp
  logic       clk_i;
  logic       arst_n_i;
  flit_t      in_flit [4];
  logic [3:0] out_rdy;
  logic       a_req_ready_o;
  logic       a_rsp_ready_o;
  logic       b_req_ready_o;
  logic       b_rsp_ready_o;
  flit_t      a_req_o;
  flit_t      a_rsp_o;
  flit_t      b_req_o;
  flit_t      b_rsp_o;

  // Send and expected queues, indexed by slot
  flit_data_t  send_mem [4][QDepth];
  flit_data_t  exp_mem [4][QDepth];
  int          send_wr [4];
  int          send_rd [4];
  int          exp_wr [4];
  int          exp_rd [4];
  int          acc_cnt [4];
  logic [39:0] records [MaxRecords];
  int          num_records;
  logic        records_loaded;

  // Traffic modes
  logic         bp_random;
  logic [3:0]   hold_low;
  logic         alt_check_en;
  channel_hdr_e alt_hdr;
  logic [3:0]   rdy_seen;
  logic [31:0]  rng_state;

  noc_axis_link #(
    .FifoDepth (FifoDepth)
  ) dut0 (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .a_req_i       (in_flit[0]),
    .a_rsp_i       (in_flit[1]),
    .a_req_ready_o (a_req_ready_o),
    .a_rsp_ready_o (a_rsp_ready_o),
    .a_req_o       (a_req_o),
    .a_rsp_o       (a_rsp_o),
    .a_req_ready_i (out_rdy[0]),
    .a_rsp_ready_i (out_rdy[1]),
    .b_req_i       (in_flit[2]),
    .b_rsp_i       (in_flit[3]),
    .b_req_ready_o (b_req_ready_o),
    .b_rsp_ready_o (b_rsp_ready_o),
    .b_req_o       (b_req_o),
    .b_rsp_o       (b_rsp_o),
    .b_req_ready_i (out_rdy[2]),
    .b_rsp_ready_i (out_rdy[3])
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic flit_t out_flit_of(input int q);
    case (q)
      0:       return a_req_o;
      1:       return a_rsp_o;
      2:       return b_req_o;
      default: return b_rsp_o;
    endcase
  endfunction

  function automatic logic in_ready_of(input int q);
    case (q)
      0:       return a_req_ready_o;
      1:       return a_rsp_ready_o;
      2:       return b_req_ready_o;
      default: return b_rsp_ready_o;
    endcase
  endfunction

  function automatic string out_name(input int q);
    case (q)
      0:       return "a_req_o.data";
      1:       return "a_rsp_o.data";
      2:       return "b_req_o.data";
      default: return "b_rsp_o.data";
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_flit(input string name, input flit_data_t got, input flit_data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run("flit payload mismatch");
    end
  endtask

  task automatic check_channel(input string name, input channel_hdr_e got,
                               input channel_hdr_e exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
               exp.name());
      abort_run("channel order mismatch");
    end
  endtask

  // Sent on one side, expected on the same channel of the other side
  task automatic queue_flit(input int side, input int chan, input flit_data_t data);
    int qs;
    int qe;
    qs = side * 2 + chan;
    qe = qs ^ 2;
    if (send_wr[qs] >= QDepth || exp_wr[qe] >= QDepth) begin
      abort_run("testbench flit queue overflow");
    end
    send_mem[qs][send_wr[qs]] = data;
    send_wr[qs]++;
    exp_mem[qe][exp_wr[qe]] = data;
    exp_wr[qe]++;
  endtask

  function automatic logic all_drained();
    int q;
    for (q = 0; q < 4; q++) begin
      if (send_rd[q] != send_wr[q] || exp_rd[q] != exp_wr[q] || in_flit[q].valid) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // No flit output valid, whatever its ready
  function automatic logic outputs_idle();
    int    q;
    flit_t f;
    for (q = 0; q < 4; q++) begin
      f = out_flit_of(q);
      if (f.valid !== 1'b0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic update_readies();
    int q;
    for (q = 0; q < 4; q++) begin
      if (hold_low[q]) begin
        out_rdy[q] = 1'b0;
      end else if (bp_random) begin
        // Low about a third of the time
        rng_state  = xorshift32(rng_state);
        out_rdy[q] = (rng_state % 3) != 0;
      end else begin
        out_rdy[q] = 1'b1;
      end
    end
  endtask

  task automatic load_inputs();
    int q;
    for (q = 0; q < 4; q++) begin
      if (!in_flit[q].valid && send_rd[q] != send_wr[q]) begin
        in_flit[q].valid = 1'b1;
        in_flit[q].data  = send_mem[q][send_rd[q]];
      end
    end
  endtask

  ////////////////////////////////////////
  // One clock cycle of traffic
  ////////////////////////////////////////

  task automatic step();
    logic [3:0]   in_fire;
    logic [3:0]   out_fire;
    flit_t        f;
    channel_hdr_e got_hdr;
    int           q;
    // Mid-cycle sample, all inputs settled since the drive point
    @(negedge clk_i);
    for (q = 0; q < 4; q++) begin
      f           = out_flit_of(q);
      rdy_seen[q] = in_ready_of(q);
      in_fire[q]  = in_flit[q].valid & rdy_seen[q];
      out_fire[q] = f.valid & out_rdy[q];
      if (out_fire[q]) begin
        if (exp_rd[q] == exp_wr[q]) begin
          abort_run($sformatf("unexpected flit on %s at %0t ns", out_name(q), $time));
        end
        check_flit(out_name(q), f.data, exp_mem[q][exp_rd[q]]);
        exp_rd[q]++;
      end
    end
    if (a_req_o.valid && a_rsp_o.valid) begin
      abort_run("side A request and response outputs valid together");
    end
    if (b_req_o.valid && b_rsp_o.valid) begin
      abort_run("side B request and response outputs valid together");
    end
    // Side A grant order
    if (alt_check_en && (in_fire[0] || in_fire[1])) begin
      got_hdr = in_fire[1] ? response : request;
      check_channel("side A grant", got_hdr, alt_hdr);
      alt_hdr = (alt_hdr == request) ? response : request;
    end
    @(posedge clk_i);
    #2;
    for (q = 0; q < 4; q++) begin
      if (in_fire[q]) begin
        acc_cnt[q]++;
        send_rd[q]++;
        in_flit[q] = '0;
      end
    end
    load_inputs();
    update_readies();
  endtask

  task automatic load_records();
    int i;
    for (i = 0; i < MaxRecords; i++) begin
      records[i] = '1;
    end
    $readmemh("testbench/noc_axis_link_testdata.txt", records);
    num_records = 0;
    // Side field above 1 ends the list
    while (num_records < MaxRecords && records[num_records][39:36] <= 4'd1) begin
      if (records[num_records][35:32] > 4'd1) begin
        abort_run("bad channel field in the testdata file");
      end
      num_records++;
    end
    if (num_records == 0) begin
      abort_run("no records found in the testdata file");
    end
    records_loaded = 1'b1;
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin : watchdog
    int limit;
    wait (records_loaded);
    limit = num_records * 40 + 200;
    repeat (limit) @(posedge clk_i);
    abort_run($sformatf("timeout, traffic did not finish within %0d cycles", limit));
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    int    q;
    int    i;
    int    base;
    flit_t f;
    arst_n_i       = 1'b0;
    out_rdy        = 4'b1111;
    bp_random      = 1'b0;
    hold_low       = 4'b0000;
    alt_check_en   = 1'b0;
    alt_hdr        = request;
    rdy_seen       = '0;
    rng_state      = 32'd20145;
    records_loaded = 1'b0;
    num_records    = 0;
    for (q = 0; q < 4; q++) begin
      in_flit[q] = '0;
      send_wr[q] = 0;
      send_rd[q] = 0;
      exp_wr[q]  = 0;
      exp_rd[q]  = 0;
      acc_cnt[q] = 0;
    end
    load_records();
    repeat (3) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    // Idle after reset, no output may be valid
    repeat (5) begin
      @(negedge clk_i);
      for (q = 0; q < 4; q++) begin
        f = out_flit_of(q);
        if (f.valid !== 1'b0) begin
          abort_run($sformatf("%s valid without traffic after reset", out_name(q)));
        end
      end
    end
    @(posedge clk_i);
    #2;

    // Both side A channels busy, side B always ready
    alt_check_en = 1'b1;
    for (i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      queue_flit(0, 0, rng_state);
      rng_state = xorshift32(rng_state);
      queue_flit(0, 1, rng_state);
    end
    while (!all_drained()) step();
    alt_check_en = 1'b0;

    // Stall b_req output, FIFO fills and a_req ready drops
    hold_low = 4'b0100;
    update_readies();
    base = acc_cnt[0];
    for (i = 0; i < FifoDepth + 3; i++) begin
      rng_state = xorshift32(rng_state);
      queue_flit(0, 0, rng_state);
    end
    while (acc_cnt[0] - base < FifoDepth) step();
    repeat (4) step();
    if (acc_cnt[0] - base != FifoDepth) begin
      abort_run("side A request took more flits than the stalled FIFO holds");
    end
    if (rdy_seen[0] !== 1'b0) begin
      abort_run("a_req_ready_o stayed high with the lane FIFO full");
    end
    hold_low = 4'b0000;
    update_readies();
    while (!all_drained()) step();

    // File traffic both ways under random back-pressure
    bp_random = 1'b1;
    for (i = 0; i < num_records; i++) begin
      queue_flit(int'(records[i][39:36]), int'(records[i][35:32]), records[i][31:0]);
    end
    while (!all_drained()) step();
    repeat (3) step();

    // Link must be empty once every expected flit has arrived
    if (outputs_idle()) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("flit output still valid after all traffic drained");
    end
  end

endmodule

`default_nettype wire

// ==== testbench/noc_axis_link_testdata.txt ====
// Columns: side digit, channel digit, then 32-bit payload, all hex
// Side 0 is A and 1 is B, channel 0 is request and 1 is response
00_a0000001
00_a0000002
01_a1000001
10_b0000001
11_b1000001
00_a0000003
01_a1000002
10_b0000002
10_b0000003
11_b1000002
00_a0000004
01_a1000003
11_b1000003
10_b0000004
00_a0000005
01_a1000004
10_b0000005
11_b1000004

// ==== verilog/noc_axis_link.sv ====
// Top level of the point-to-point NoC link.
// Two bridges back to back, lane_ab from side A to side B and lane_ba
// the other way. FifoDepth sizes both transmit FIFOs.

`timescale 1ns/1ps
`default_nettype none

module noc_axis_link
  import noc_bridge_pkg::*;
#(
  parameter int unsigned FifoDepth = 2
) (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  // Side A into the link
  input  wire flit_t a_req_i,
  input  wire flit_t a_rsp_i,
  output logic       a_req_ready_o,
  output logic       a_rsp_ready_o,
  // Side A out of the link
  output flit_t      a_req_o,
  output flit_t      a_rsp_o,
  input  wire logic  a_req_ready_i,
  input  wire logic  a_rsp_ready_i,
  // Side B into the link
  input  wire flit_t b_req_i,
  input  wire flit_t b_rsp_i,
  output logic       b_req_ready_o,
  output logic       b_rsp_ready_o,
  // Side B out of the link
  output flit_t      b_req_o,
  output flit_t      b_rsp_o,
  input  wire logic  b_req_ready_i,
  input  wire logic  b_rsp_ready_i
);

  ////////////////////////////////////////
  // AXIS lanes
  ////////////////////////////////////////

  // A to B
  axis_req_t lane_ab_req;
  axis_rsp_t lane_ab_rsp;
  // B to A
  axis_req_t lane_ba_req;
  axis_rsp_t lane_ba_rsp;

  noc_axis_bridge #(
    .FifoDepth (FifoDepth)
  ) bridge_a (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_i          (a_req_i),
    .rsp_i          (a_rsp_i),
    .req_ready_o    (a_req_ready_o),
    .rsp_ready_o    (a_rsp_ready_o),
    .req_o          (a_req_o),
    .rsp_o          (a_rsp_o),
    .req_ready_i    (a_req_ready_i),
    .rsp_ready_i    (a_rsp_ready_i),
    .axis_out_req_o (lane_ab_req),
    .axis_out_rsp_i (lane_ab_rsp),
    .axis_in_req_i  (lane_ba_req),
    .axis_in_rsp_o  (lane_ba_rsp)
  );

  noc_axis_bridge #(
    .FifoDepth (FifoDepth)
  ) bridge_b (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_i          (b_req_i),
    .rsp_i          (b_rsp_i),
    .req_ready_o    (b_req_ready_o),
    .rsp_ready_o    (b_rsp_ready_o),
    .req_o          (b_req_o),
    .rsp_o          (b_rsp_o),
    .req_ready_i    (b_req_ready_i),
    .rsp_ready_i    (b_rsp_ready_i),
    .axis_out_req_o (lane_ba_req),
    .axis_out_rsp_i (lane_ba_rsp),
    .axis_in_req_i  (lane_ab_req),
    .axis_in_rsp_o  (lane_ab_rsp)
  );

endmodule

`default_nettype wire
